// File: src/isaPkg.sv
package isaPkg;

	localparam int instrWidth = 28;
	localparam int dataWidth = 16;
	localparam int addrWidth = 8;
	localparam int opWidth = 4;
	localparam int memDepth = 1 << addrWidth;	// words in the rom and in the ram.

	// ===================================================================
	// opcodes, code 14 is unused and executes as a nop.
	localparam logic [opWidth-1:0] opNop = 4'h0;
	localparam logic [opWidth-1:0] opAdd = 4'h1;
	localparam logic [opWidth-1:0] opSub = 4'h2;
	localparam logic [opWidth-1:0] opSmul = 4'h3;	// product lands in RL and RH.
	localparam logic [opWidth-1:0] opSto = 4'h4;
	localparam logic [opWidth-1:0] opBle = 4'h5;	// target is the destination field.
	localparam logic [opWidth-1:0] opJmp = 4'h6;
	localparam logic [opWidth-1:0] opCall = 4'h7;
	localparam logic [opWidth-1:0] opRet = 4'h8;
	localparam logic [opWidth-1:0] opLed = 4'h9;
	localparam logic [opWidth-1:0] opLcdChar = 4'hA;
	localparam logic [opWidth-1:0] opLcdCmd = 4'hB;
	localparam logic [opWidth-1:0] opLcdEnb = 4'hC;
	localparam logic [opWidth-1:0] opShl = 4'hD;
	localparam logic [opWidth-1:0] opHalt = 4'hF;

	// source addresses that read RL and RH instead of the data ram.
	localparam logic [addrWidth-1:0] regRl = 8'd254;
	localparam logic [addrWidth-1:0] regRh = 8'd255;

	// ===================================================================
	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [addrWidth-1:0] destination;
		logic [addrWidth-1:0] source1;
		logic [addrWidth-1:0] source0;
	} regFormT;

	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [addrWidth-1:0] destination;
		logic [dataWidth-1:0] immediate;	// low byte is the jmp and call target.
	} immFormT;

	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instrT;

	localparam instrT instrNop = '0;

endpackage

// File: src/busPkg.sv
package busPkg;

	localparam int wbAddrWidth = 10;
	localparam int wbDataWidth = 32;

	// ===================================================================
	// word address map.
	localparam logic [wbAddrWidth-1:0] adrProgBase = 10'd0;	// 256 program words.
	localparam logic [wbAddrWidth-1:0] adrControl = 10'd256;
	localparam logic [wbAddrWidth-1:0] adrStatus = 10'd257;
	localparam logic [wbAddrWidth-1:0] adrOutputs = 10'd258;

	// control word.
	localparam int ctrlRun = 0;

	// status word.
	localparam int statHalted = 0;
	localparam int statIpLsb = 8;

	// output word, one byte each.
	localparam int outLedLsb = 0;
	localparam int outLcdLsb = 8;

endpackage

// File: src/programRom.sv
module programRom
(
	input logic Clock,
	input logic progWe,
	input logic [isaPkg::addrWidth-1:0] progAddr,
	input isaPkg::instrT progData,
	input logic [isaPkg::addrWidth-1:0] romAddr,
	output isaPkg::instrT instr
);

	isaPkg::instrT mem [isaPkg::memDepth];

	// words the host never loads decode as nop.
	initial
	begin
		for (int i = 0; i < isaPkg::memDepth; i++)
		begin
			mem[i] = isaPkg::instrNop;
		end
	end

	// host side, one word per acknowledged write.
	always @(posedge Clock)
	begin
		if (progWe)
		begin
			mem[progAddr] <= progData;
		end
	end

	assign instr = mem[romAddr];	// fetch reads without a clock.

endmodule

// File: src/dataRam.sv
module dataRam
(
	input logic Clock,
	input logic ramWe,
	input logic [isaPkg::addrWidth-1:0] ramWrAddr,
	input logic [isaPkg::dataWidth-1:0] ramWrData,
	input logic [isaPkg::addrWidth-1:0] ramRdAddr0,
	input logic [isaPkg::addrWidth-1:0] ramRdAddr1,
	output logic [isaPkg::dataWidth-1:0] ramRdData0,
	output logic [isaPkg::dataWidth-1:0] ramRdData1
);

	logic [isaPkg::dataWidth-1:0] mem [isaPkg::memDepth];

	// ===================================================================
	// single write port, visible to readers after the edge.

	always_ff @(posedge Clock)
	begin
		if (ramWe)
		begin
			mem[ramWrAddr] <= ramWrData;
		end
	end

	// ===================================================================
	// two independent read ports for source0 and source1.

	assign ramRdData0 = mem[ramRdAddr0];
	assign ramRdData1 = mem[ramRdAddr1];

endmodule

// File: src/miniAluCore.sv
module miniAluCore
(
	input logic Clock,
	input logic reset,
	input logic run,
	input logic start,
	output logic [isaPkg::addrWidth-1:0] romAddr,
	input isaPkg::instrT instr,
	output logic [isaPkg::addrWidth-1:0] ramRdAddr0,
	output logic [isaPkg::addrWidth-1:0] ramRdAddr1,
	input logic [isaPkg::dataWidth-1:0] ramRdData0,
	input logic [isaPkg::dataWidth-1:0] ramRdData1,
	output logic ramWe,
	output logic [isaPkg::addrWidth-1:0] ramWrAddr,
	output logic [isaPkg::dataWidth-1:0] ramWrData,
	output logic halted,
	output logic [isaPkg::addrWidth-1:0] ip,
	output logic [7:0] led,
	output logic [7:0] lcd
);

	isaPkg::instrT fetchReg;	// instruction in execute.
	logic [isaPkg::opWidth-1:0] execOp;
	logic [isaPkg::addrWidth-1:0] retReg;
	logic [isaPkg::addrWidth-1:0] target;
	logic [isaPkg::dataWidth-1:0] rl;
	logic [isaPkg::dataWidth-1:0] rh;
	logic [isaPkg::dataWidth-1:0] result;
	logic signed [isaPkg::dataWidth-1:0] src0;
	logic signed [isaPkg::dataWidth-1:0] src1;
	logic signed [2*isaPkg::dataWidth-1:0] product;
	logic fetchEn;
	logic writeEn;
	logic branchTaken;
	logic ledEn;
	logic mulEn;
	logic lcdLoad;
	logic lcdToggle;
	logic callEn;
	logic haltNow;

	// the last result still waits in the write stage, so it wins over ram.
	function automatic logic [isaPkg::dataWidth-1:0] selectSource
	(
		input logic [isaPkg::addrWidth-1:0] addr,
		input logic [isaPkg::dataWidth-1:0] ramData
	);
		logic [isaPkg::dataWidth-1:0] value;
		if (addr == isaPkg::regRl)
			value = rl;
		else if (addr == isaPkg::regRh)
			value = rh;
		else
			value = ramData;
		if (ramWe && addr == ramWrAddr)
			value = ramWrData;	// forwarding.
		return value;
	endfunction

	// ===================================================================
	// decode and operands

	assign execOp = fetchReg.regForm.opcode;
	assign ramRdAddr0 = fetchReg.regForm.source0;
	assign ramRdAddr1 = fetchReg.regForm.source1;

	always_comb
	begin
		src0 = selectSource(ramRdAddr0, ramRdData0);
		src1 = selectSource(ramRdAddr1, ramRdData1);
	end

	assign product = src1 * src0;	// signed, full 32 bits.

	// a taken branch steers this cycle's fetch, no slot behind it.
	assign romAddr = branchTaken ? target : ip;
	assign fetchEn = run & ~halted & ~haltNow;

	// ===================================================================
	// execute

	always_comb
	begin
		writeEn = 1'b0;
		result = '0;
		branchTaken = 1'b0;
		target = fetchReg.immForm.immediate[isaPkg::addrWidth-1:0];
		ledEn = 1'b0;
		mulEn = 1'b0;
		lcdLoad = 1'b0;
		lcdToggle = 1'b0;
		callEn = 1'b0;
		haltNow = 1'b0;
		case (execOp)
			isaPkg::opAdd:
			begin
				writeEn = 1'b1;
				result = src1 + src0;
			end
			isaPkg::opSub:
			begin
				writeEn = 1'b1;
				result = src1 - src0;
			end
			isaPkg::opShl:
			begin
				writeEn = 1'b1;
				result = src1 << src0;
			end
			isaPkg::opSto:
			begin
				writeEn = 1'b1;
				result = fetchReg.immForm.immediate;
			end
			isaPkg::opSmul: mulEn = 1'b1;
			isaPkg::opBle:
			begin
				branchTaken = (src1 <= src0);	// signed compare.
				target = fetchReg.regForm.destination;
			end
			isaPkg::opJmp: branchTaken = 1'b1;
			isaPkg::opCall:
			begin
				branchTaken = 1'b1;
				callEn = 1'b1;
			end
			isaPkg::opRet:
			begin
				branchTaken = 1'b1;
				target = retReg;
			end
			isaPkg::opLed: ledEn = 1'b1;
			isaPkg::opLcdChar, isaPkg::opLcdCmd: lcdLoad = 1'b1;
			isaPkg::opLcdEnb: lcdToggle = 1'b1;
			isaPkg::opHalt: haltNow = 1'b1;
			default: ;	// nop and the spare code.
		endcase
	end

	// ===================================================================
	// pipeline control

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			ip <= '0;
			fetchReg <= isaPkg::instrNop;
			halted <= 1'b0;
			ramWe <= 1'b0;
		end
		else
		begin
			ramWe <= writeEn;
			if (start)
			begin
				ip <= '0;
				fetchReg <= isaPkg::instrNop;
				halted <= 1'b0;
			end
			else
			begin
				if (haltNow)
					halted <= 1'b1;
				if (fetchEn)
				begin
					fetchReg <= instr;
					ip <= romAddr + 1'b1;
				end
				else
					fetchReg <= isaPkg::instrNop;	// bubble while stopped.
			end
		end
	end

	// write stage and special registers.
	always_ff @(posedge Clock)
	begin
		ramWrAddr <= fetchReg.regForm.destination;
		ramWrData <= result;
		if (mulEn)
		begin
			rl <= product[isaPkg::dataWidth-1:0];
			rh <= product[2*isaPkg::dataWidth-1:isaPkg::dataWidth];
		end
		if (callEn)
			retReg <= ip;	// already one past the call.
	end

	// lcd byte is {backlight, rw, rs, enable, data nibble}.
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			led <= '0;
			lcd <= '0;
		end
		else
		begin
			if (ledEn)
				led <= src1[7:0];
			if (lcdLoad)
				lcd <= {1'b1, 1'b0, execOp == isaPkg::opLcdChar, lcd[4], src1[7:4]};
			else if (lcdToggle)
				lcd <= {1'b1, lcd[6:5], ~lcd[4], lcd[3:0]};
		end
	end

endmodule

// File: src/hostPort.sv
module hostPort
(
	input logic Clock,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [busPkg::wbAddrWidth-1:0] wbAdr,
	input logic [busPkg::wbDataWidth-1:0] wbDatIn,
	output logic [busPkg::wbDataWidth-1:0] wbDatOut,
	output logic wbAck,
	output logic progWe,
	output logic [isaPkg::addrWidth-1:0] progAddr,
	output isaPkg::instrT progData,
	output logic run,
	output logic start,
	input logic halted,
	input logic [isaPkg::addrWidth-1:0] ip,
	input logic [7:0] led,
	input logic [7:0] lcd
);

	logic request;
	logic isProg;
	logic ctrlWrite;
	logic [busPkg::wbDataWidth-1:0] readWord;

	assign request = wbCyc & wbStb & ~wbAck;	// no new cycle while acking.
	assign isProg = (wbAdr >> isaPkg::addrWidth) == (busPkg::adrProgBase >> isaPkg::addrWidth);
	assign ctrlWrite = wbAck & wbCyc & wbStb & wbWe & (wbAdr == busPkg::adrControl);

	// the ack cycle carries the write strobes to the rom and the core.
	assign progWe = wbAck & wbCyc & wbStb & wbWe & isProg;
	assign progAddr = wbAdr[isaPkg::addrWidth-1:0];
	assign progData = isaPkg::instrT'(wbDatIn[isaPkg::instrWidth-1:0]);
	assign start = ctrlWrite & wbDatIn[busPkg::ctrlRun];

	always_comb
	begin
		readWord = '0;
		case (wbAdr)
			busPkg::adrControl: readWord[busPkg::ctrlRun] = run;
			busPkg::adrStatus:
			begin
				readWord[busPkg::statHalted] = halted;
				readWord[busPkg::statIpLsb +: isaPkg::addrWidth] = ip;
			end
			busPkg::adrOutputs:
			begin
				readWord[busPkg::outLedLsb +: 8] = led;
				readWord[busPkg::outLcdLsb +: 8] = lcd;
			end
			default: readWord = '0;	// program words are write only.
		endcase
	end

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			wbAck <= 1'b0;
			run <= 1'b0;
		end
		else
		begin
			wbAck <= request;
			if (ctrlWrite)
				run <= wbDatIn[busPkg::ctrlRun];
		end
	end

	// sampled with the request, held through the ack.
	always_ff @(posedge Clock)
	begin
		if (request)
			wbDatOut <= readWord;
	end

endmodule

// File: src/miniAluSystem.sv
module miniAluSystem
(
	input logic Clock,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [busPkg::wbAddrWidth-1:0] wbAdr,
	input logic [busPkg::wbDataWidth-1:0] wbDatIn,
	output logic [busPkg::wbDataWidth-1:0] wbDatOut,
	output logic wbAck,
	output logic [7:0] led,
	output logic [7:0] lcd
);

	logic progWe;
	logic [isaPkg::addrWidth-1:0] progAddr;
	isaPkg::instrT progData;
	logic run;
	logic start;
	logic halted;
	logic [isaPkg::addrWidth-1:0] ip;

	// ===================================================================
	// host side

	hostPort host0
	(
		.Clock(Clock), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.run(run), .start(start), .halted(halted), .ip(ip), .led(led), .lcd(lcd)
	);

	// ===================================================================
	// processor and its memories

	logic [isaPkg::addrWidth-1:0] romAddr;
	isaPkg::instrT instr;
	logic [isaPkg::addrWidth-1:0] ramRdAddr0;
	logic [isaPkg::addrWidth-1:0] ramRdAddr1;
	logic [isaPkg::dataWidth-1:0] ramRdData0;
	logic [isaPkg::dataWidth-1:0] ramRdData1;
	logic ramWe;
	logic [isaPkg::addrWidth-1:0] ramWrAddr;
	logic [isaPkg::dataWidth-1:0] ramWrData;

	programRom rom0
	(
		.Clock(Clock), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.romAddr(romAddr), .instr(instr)
	);

	dataRam ram0
	(
		.Clock(Clock), .ramWe(ramWe), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData),
		.ramRdAddr0(ramRdAddr0), .ramRdAddr1(ramRdAddr1),
		.ramRdData0(ramRdData0), .ramRdData1(ramRdData1)
	);

	miniAluCore core0
	(
		.Clock(Clock), .reset(reset), .run(run), .start(start),
		.romAddr(romAddr), .instr(instr),
		.ramRdAddr0(ramRdAddr0), .ramRdAddr1(ramRdAddr1),
		.ramRdData0(ramRdData0), .ramRdData1(ramRdData1),
		.ramWe(ramWe), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData),
		.halted(halted), .ip(ip), .led(led), .lcd(lcd)
	);

endmodule

// File: dv/miniAluBus_assert.sv
module miniAluBus_assert
(
	input logic Clock,
	input logic reset,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic ramWe,
	input logic halted
);

	int failCount = 0;	// failed assertions so far.

	ackOneCycle: assert property (@(posedge Clock) disable iff (reset) wbAck |=> !wbAck)
	else
	begin
		failCount++;
		$error("wbAck held for more than one cycle");
	end

	// the request must have been seen in the cycle before the ack.
	ackAfterRequest: assert property (@(posedge Clock) disable iff (reset)
		wbAck |-> $past(wbCyc && wbStb && !wbAck))
	else
	begin
		failCount++;
		$error("wbAck without a request in the cycle before");
	end

	noWriteHalted: assert property (@(posedge Clock) disable iff (reset) halted |-> !ramWe)
	else
	begin
		failCount++;
		$error("ramWe high while the core is halted");
	end

endmodule

// ===================================================================
// attached where the host port handshake and the core outputs meet.

bind miniAluSystem miniAluBus_assert busChk
(
	.Clock(Clock), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
	.ramWe(ramWe), .halted(halted)
);

// File: dv/tbMiniAlu.sv
module tbMiniAlu;

	// about 160 program words at 3 bus cycles each, five runs and their status polls.
	localparam int cycleLimit = 4000;
	localparam int ackLimit = 8;	// cycles a bus cycle may wait for wbAck.
	localparam int pollLimit = 100;	// status reads before a run counts as stuck.

	logic Clock;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [busPkg::wbAddrWidth-1:0] wbAdr;
	logic [busPkg::wbDataWidth-1:0] wbDatIn;
	logic [busPkg::wbDataWidth-1:0] wbDatOut;
	logic wbAck;
	logic [7:0] led;
	logic [7:0] lcd;

	// program image and the state of the ISA model.
	isaPkg::instrT prog [isaPkg::memDepth];
	int progLen;
	logic [isaPkg::dataWidth-1:0] mRam [isaPkg::memDepth];
	logic [isaPkg::dataWidth-1:0] mRl;
	logic [isaPkg::dataWidth-1:0] mRh;
	logic [isaPkg::addrWidth-1:0] mRet;
	logic [7:0] mLed;
	logic [7:0] mLcd;
	logic [7:0] expLed [$];
	logic [7:0] expLcd [$];

	logic [31:0] lcgState;
	int cycleCount;
	int valueErrors;
	int busErrors;
	int assertErrors;
	logic [7:0] seenLed;
	logic [7:0] seenLcd;
	logic [7:0] wantLed;
	logic [7:0] wantLcd;

	miniAluSystem dut0
	(
		.Clock(Clock), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
		.led(led), .lcd(lcd)
	);

	initial
	begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	always @(posedge Clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout, the run went past %0d cycles", cycleLimit);
			$display("Checks failed");
			$finish;
		end
	end

	// ===================================================================
	// stimulus helpers

	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	function automatic isaPkg::instrT regInstr
	(
		input logic [isaPkg::opWidth-1:0] op,
		input logic [7:0] dst,
		input logic [7:0] s1,
		input logic [7:0] s0
	);
		isaPkg::instrT word;
		word.regForm.opcode = op;
		word.regForm.destination = dst;
		word.regForm.source1 = s1;
		word.regForm.source0 = s0;
		return word;
	endfunction

	function automatic isaPkg::instrT immInstr
	(
		input logic [isaPkg::opWidth-1:0] op,
		input logic [7:0] dst,
		input logic [15:0] imm
	);
		isaPkg::instrT word;
		word.immForm.opcode = op;
		word.immForm.destination = dst;
		word.immForm.immediate = imm;
		return word;
	endfunction

	function automatic void emit(input isaPkg::instrT word);
		prog[progLen] = word;
		progLen++;
	endfunction

	// ===================================================================
	// reference ISA model, one instruction per step in program order

	function automatic logic [15:0] sourceValue(input logic [7:0] addr);
		if (addr == isaPkg::regRl)
			return mRl;
		if (addr == isaPkg::regRh)
			return mRh;
		return mRam[addr];
	endfunction

	// fills expLed and expLcd with the visible changes and returns the final IP.
	function automatic logic [7:0] runIsa();
		isaPkg::instrT ins;
		logic [7:0] pc;
		logic [7:0] dst;
		logic signed [15:0] a1;
		logic signed [15:0] a0;
		logic signed [31:0] prod;
		logic [7:0] nextLcd;
		pc = 8'd0;
		for (int steps = 0; steps < 2000; steps++)
		begin
			ins = prog[pc];
			pc = pc + 8'd1;
			dst = ins.regForm.destination;
			a1 = sourceValue(ins.regForm.source1);
			a0 = sourceValue(ins.regForm.source0);
			nextLcd = mLcd;
			case (ins.regForm.opcode)
				isaPkg::opAdd: mRam[dst] = a1 + a0;
				isaPkg::opSub: mRam[dst] = a1 - a0;
				isaPkg::opShl: mRam[dst] = a1 << a0;
				isaPkg::opSto: mRam[dst] = ins.immForm.immediate;
				isaPkg::opSmul:
				begin
					prod = 32'(a1) * 32'(a0);
					mRl = prod[15:0];
					mRh = prod[31:16];
				end
				isaPkg::opBle:
				begin
					if (a1 <= a0)
						pc = dst;
				end
				isaPkg::opJmp: pc = ins.immForm.immediate[7:0];
				isaPkg::opCall:
				begin
					mRet = pc;
					pc = ins.immForm.immediate[7:0];
				end
				isaPkg::opRet: pc = mRet;
				isaPkg::opLed:
				begin
					if (a1[7:0] != mLed)
						expLed.push_back(a1[7:0]);
					mLed = a1[7:0];
				end
				// backlight, rw, rs, enable, data nibble.
				isaPkg::opLcdChar: nextLcd = {2'b10, 1'b1, mLcd[4], a1[7:4]};
				isaPkg::opLcdCmd: nextLcd = {2'b10, 1'b0, mLcd[4], a1[7:4]};
				isaPkg::opLcdEnb: nextLcd = {1'b1, mLcd[6:5], ~mLcd[4], mLcd[3:0]};
				isaPkg::opHalt: return pc;
				default: ;
			endcase
			if (nextLcd != mLcd)
				expLcd.push_back(nextLcd);
			mLcd = nextLcd;
		end
		return pc;
	endfunction

	// ===================================================================
	// Wishbone master

	task automatic busCycle
	(
		input logic we,
		input logic [busPkg::wbAddrWidth-1:0] adr,
		input logic [busPkg::wbDataWidth-1:0] dat,
		output logic [busPkg::wbDataWidth-1:0] rdata
	);
		int edges;
		rdata = '0;
		@(posedge Clock);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe <= we;
		wbAdr <= adr;
		wbDatIn <= dat;
		edges = 0;
		do
		begin
			@(posedge Clock);
			edges++;
		end
		while (!wbAck && edges < ackLimit);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe <= 1'b0;
		if (!wbAck)
		begin
			busErrors++;
			$display("no wbAck within %0d cycles for address %0d", ackLimit, adr);
		end
		else
		begin
			rdata = wbDatOut;
			if (edges != 2)
			begin
				busErrors++;
				$display("wbAck for address %0d came %0d cycles after the request",
					adr, edges - 1);
			end
		end
	endtask

	task automatic wbWrite
	(
		input logic [busPkg::wbAddrWidth-1:0] adr,
		input logic [busPkg::wbDataWidth-1:0] dat
	);
		logic [busPkg::wbDataWidth-1:0] ignored;
		busCycle(1'b1, adr, dat, ignored);
	endtask

	task automatic wbRead
	(
		input logic [busPkg::wbAddrWidth-1:0] adr,
		output logic [busPkg::wbDataWidth-1:0] dat
	);
		busCycle(1'b0, adr, '0, dat);
	endtask

	task automatic loadProgram();
		for (int i = 0; i < progLen; i++)
			wbWrite(busPkg::adrProgBase + 10'(i), {4'd0, prog[i]});
	endtask

	// starts the core, waits for HALT and checks status, outputs and the queues.
	task automatic startAndCheck(input logic [7:0] expIp);
		logic [busPkg::wbDataWidth-1:0] status;
		logic [busPkg::wbDataWidth-1:0] outWord;
		int polls;
		wbWrite(busPkg::adrControl, 32'd1 << busPkg::ctrlRun);
		wbRead(busPkg::adrStatus, status);
		if (status[busPkg::statHalted] != 1'b0)
		begin
			valueErrors++;
			$display("FAIL %0t halted got %b expected 0", $time, status[busPkg::statHalted]);
		end
		polls = 0;
		while (!status[busPkg::statHalted] && polls < pollLimit)
		begin
			wbRead(busPkg::adrStatus, status);
			polls++;
		end
		if (!status[busPkg::statHalted])
		begin
			valueErrors++;
			$display("the core did not halt within %0d status reads", pollLimit);
		end
		else if (status[busPkg::statIpLsb +: 8] != expIp)
		begin
			valueErrors++;
			$display("FAIL %0t ip got %0d expected %0d", $time,
				status[busPkg::statIpLsb +: 8], expIp);
		end
		// the output word mirrors the last led and lcd values.
		wbRead(busPkg::adrOutputs, outWord);
		if (outWord[busPkg::outLedLsb +: 8] != mLed)
		begin
			valueErrors++;
			$display("FAIL %0t output word led got %h expected %h", $time,
				outWord[busPkg::outLedLsb +: 8], mLed);
		end
		if (outWord[busPkg::outLcdLsb +: 8] != mLcd)
		begin
			valueErrors++;
			$display("FAIL %0t output word lcd got %h expected %h", $time,
				outWord[busPkg::outLcdLsb +: 8], mLcd);
		end
		if (expLed.size() != 0)
		begin
			valueErrors++;
			$display("%0d expected led values never appeared", expLed.size());
		end
		if (expLcd.size() != 0)
		begin
			valueErrors++;
			$display("%0d expected lcd bytes never appeared", expLcd.size());
		end
		expLed.delete();
		expLcd.delete();
	endtask

	// ===================================================================
	// test programs

	task automatic arithProgram();
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] sh;
		progLen = 0;
		for (int i = 0; i < 10; i++)
		begin
			x = nextRand();
			y = nextRand();
			sh = nextRand() & 16'h0007;
			emit(immInstr(isaPkg::opSto, 8'd15, sh));
			emit(immInstr(isaPkg::opSto, 8'd10, x));
			emit(immInstr(isaPkg::opSto, 8'd11, y));
			emit(regInstr(isaPkg::opAdd, 8'd12, 8'd10, 8'd11));	// 11 forwarded.
			emit(regInstr(isaPkg::opSub, 8'd13, 8'd11, 8'd12));
			emit(regInstr(isaPkg::opShl, 8'd14, 8'd13, 8'd15));
			emit(regInstr(isaPkg::opLed, 8'd0, 8'd14, 8'd0));
			emit(regInstr(isaPkg::opLed, 8'd0, 8'd12, 8'd0));
			emit(regInstr(isaPkg::opLed, 8'd0, 8'd13, 8'd0));
		end
		emit(regInstr(isaPkg::opHalt, 8'd0, 8'd0, 8'd0));
	endtask

	task automatic mulProgram();
		logic [15:0] a;
		logic [15:0] b;
		progLen = 0;
		for (int i = 0; i < 4; i++)
		begin
			a = nextRand() | 16'h8000;
			b = (i == 3) ? (nextRand() | 16'h8000) : (nextRand() & 16'h7fff);
			emit(immInstr(isaPkg::opSto, 8'd20, a));
			emit(immInstr(isaPkg::opSto, 8'd21, b));
			emit(regInstr(isaPkg::opSmul, 8'd0, 8'd20, 8'd21));
			emit(regInstr(isaPkg::opLed, 8'd0, isaPkg::regRl, 8'd0));
			emit(regInstr(isaPkg::opLed, 8'd0, isaPkg::regRh, 8'd0));
		end
		emit(regInstr(isaPkg::opHalt, 8'd0, 8'd0, 8'd0));
	endtask

	// countdown loop, a call to a subroutine and words that must stay skipped.
	task automatic loopProgram();
		progLen = 0;
		emit(immInstr(isaPkg::opSto, 8'd30, 16'd3 + (nextRand() & 16'h0003)));
		emit(immInstr(isaPkg::opSto, 8'd31, 16'd1));
		emit(immInstr(isaPkg::opSto, 8'd32, 16'd0));
		emit(immInstr(isaPkg::opSto, 8'd33, 16'h00a5));
		emit(immInstr(isaPkg::opSto, 8'd34, 16'h005a));
		emit(regInstr(isaPkg::opLed, 8'd0, 8'd30, 8'd0));	// loop head at 5.
		emit(regInstr(isaPkg::opSub, 8'd30, 8'd30, 8'd31));
		emit(regInstr(isaPkg::opBle, 8'd10, 8'd30, 8'd32));
		emit(immInstr(isaPkg::opJmp, 8'd0, 16'd5));
		emit(regInstr(isaPkg::opLed, 8'd0, 8'd34, 8'd0));	// never reached.
		emit(immInstr(isaPkg::opCall, 8'd0, 16'd13));
		emit(regInstr(isaPkg::opLed, 8'd0, 8'd32, 8'd0));
		emit(regInstr(isaPkg::opHalt, 8'd0, 8'd0, 8'd0));
		emit(regInstr(isaPkg::opLed, 8'd0, 8'd33, 8'd0));	// subroutine.
		emit(regInstr(isaPkg::opRet, 8'd0, 8'd0, 8'd0));
	endtask

	task automatic lcdProgram();
		progLen = 0;
		for (int i = 0; i < 4; i++)
		begin
			emit(immInstr(isaPkg::opSto, 8'd40, nextRand()));
			emit(immInstr(isaPkg::opSto, 8'd41, nextRand()));
			emit(regInstr(isaPkg::opLcdCmd, 8'd0, 8'd40, 8'd0));
			emit(regInstr(isaPkg::opLcdEnb, 8'd0, 8'd0, 8'd0));
			emit(regInstr(isaPkg::opLcdEnb, 8'd0, 8'd0, 8'd0));
			emit(regInstr(isaPkg::opLcdChar, 8'd0, 8'd41, 8'd0));
			emit(regInstr(isaPkg::opLcdEnb, 8'd0, 8'd0, 8'd0));
		end
		emit(regInstr(isaPkg::opHalt, 8'd0, 8'd0, 8'd0));
	endtask

	// ===================================================================
	// output comparison, half a cycle after the registers settle

	always @(negedge Clock)
	begin
		if (!reset && led != seenLed)
		begin
			if (expLed.size() == 0)
			begin
				valueErrors++;
				$display("led changed to %h at %0t with no change expected", led, $time);
			end
			else
			begin
				wantLed = expLed.pop_front();
				if (led != wantLed)
				begin
					valueErrors++;
					$display("FAIL %0t led got %h expected %h", $time, led, wantLed);
				end
			end
			seenLed = led;
		end
		if (!reset && lcd != seenLcd)
		begin
			if (expLcd.size() == 0)
			begin
				valueErrors++;
				$display("lcd changed to %h at %0t with no change expected", lcd, $time);
			end
			else
			begin
				wantLcd = expLcd.pop_front();
				if (lcd != wantLcd)
				begin
					valueErrors++;
					$display("FAIL %0t lcd got %h expected %h", $time, lcd, wantLcd);
				end
			end
			seenLcd = lcd;
		end
	end

	// ===================================================================
	// main sequence

	initial
	begin
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		lcgState = 32'd2683;
		cycleCount = 0;
		valueErrors = 0;
		busErrors = 0;
		progLen = 0;
		mLed = 8'd0;
		mLcd = 8'd0;
		seenLed = 8'd0;
		seenLcd = 8'd0;
		repeat (4) @(posedge Clock);
		reset <= 1'b0;

		arithProgram();
		loadProgram();
		startAndCheck(runIsa());

		mulProgram();
		loadProgram();
		startAndCheck(runIsa());

		loopProgram();
		loadProgram();
		startAndCheck(runIsa());

		// stop, then rerun the same image from IP 0.
		wbWrite(busPkg::adrControl, 32'd0);
		startAndCheck(runIsa());

		lcdProgram();
		loadProgram();
		startAndCheck(runIsa());

		assertErrors = dut0.busChk.failCount;
		$display("errors: %0d value, %0d bus, %0d assertion",
			valueErrors, busErrors, assertErrors);
		if (valueErrors + busErrors + assertErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: sim.f
src/isaPkg.sv
src/busPkg.sv
src/programRom.sv
src/dataRam.sv
src/miniAluCore.sv
src/hostPort.sv
src/miniAluSystem.sv
dv/miniAluBus_assert.sv
dv/tbMiniAlu.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tbMiniAlu \
	-Mdir obj_dir -f sim.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/VtbMiniAlu +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All checks passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
